/* design/rob_defs.svh */
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// buffer geometry
`define ROB_DEPTH    16
`define ROB_IDX_W    4

// entries written per allocation group
`define ALLOC_WIDTH  4

// most entries retired in one cycle
`define COMMIT_WIDTH 4

// physical register number width
`define PREG_W       6

// occupancy count, wide enough to hold ROB_DEPTH itself
`define CNT_W        5

`endif

/* design/rob_pkg.sv */
`default_nettype none

`include "rob_defs.svh"

package rob_pkg;

    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

    typedef logic [`PREG_W-1:0] preg_t;

    // one buffer entry, 9 bits
    typedef struct packed {
        logic  valid;
        logic  done;
        logic  reg_wrt;
        preg_t free_preg;
    } rob_entry_t;

    // one bit per slot of an allocation group
    typedef logic [`ALLOC_WIDTH-1:0] slot_mask_t;

    // slot 0 in the low bits
    typedef preg_t [`ALLOC_WIDTH-1:0] preg_group_t;

endpackage

`default_nettype wire

/* design/rob_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_alloc (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc_vld,
    input  logic [2:0]        retire_cnt,
    output logic              wr_en,
    output rob_pkg::rob_idx_t tail,
    output logic              full,
    output logic              empty
);

    // entries currently in use
    logic [`CNT_W-1:0] count;

    // a group needs four free entries
    assign full  = (count > `CNT_W'(`ROB_DEPTH - `ALLOC_WIDTH));
    assign empty = (count == '0);

    // accept only while there is room
    assign wr_en = alloc_vld & ~full;

    // tail wraps on its own since depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail <= '0;
        end else if (wr_en) begin
            tail <= tail + rob_pkg::rob_idx_t'(`ALLOC_WIDTH);
        end
    end

    // occupancy tracks both sides in the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (wr_en) begin
            count <= count + `CNT_W'(`ALLOC_WIDTH) - `CNT_W'(retire_cnt);
        end else begin
            count <= count - `CNT_W'(retire_cnt);
        end
    end

endmodule

`default_nettype wire

/* design/rob_entry_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_entry_table (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_en,
    input  rob_pkg::rob_idx_t    tail,
    input  rob_pkg::slot_mask_t  alloc_slots,
    input  rob_pkg::slot_mask_t  alloc_reg_wrt,
    input  rob_pkg::preg_group_t alloc_free_preg,
    input  logic                 wb0_vld,
    input  logic                 wb1_vld,
    input  rob_pkg::rob_idx_t    wb0_idx,
    input  rob_pkg::rob_idx_t    wb1_idx,
    input  rob_pkg::rob_idx_t    head,
    input  logic [2:0]           retire_cnt,
    output rob_pkg::rob_entry_t  head_window [`COMMIT_WIDTH]
);

    // control bits
    logic [`ROB_DEPTH-1:0] vld_q;
    logic [`ROB_DEPTH-1:0] done_q;

    // payload
    logic [`ROB_DEPTH-1:0] reg_wrt_q;
    rob_pkg::preg_t        free_preg_q [`ROB_DEPTH];

    // wrapped slot positions from tail and from head
    rob_pkg::rob_idx_t alloc_idx [`ALLOC_WIDTH];
    rob_pkg::rob_idx_t win_idx   [`COMMIT_WIDTH];

    always_comb begin
        for (int i = 0; i < `ALLOC_WIDTH; i++) begin
            alloc_idx[i] = tail + rob_pkg::rob_idx_t'(i);
        end
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            win_idx[i] = head + rob_pkg::rob_idx_t'(i);
        end
    end

    // later writes win: allocation over retire clear over writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q  <= '0;
            done_q <= '0;
        end else begin
            if (wb0_vld) begin
                done_q[wb0_idx] <= 1'b1;
            end
            if (wb1_vld) begin
                done_q[wb1_idx] <= 1'b1;
            end
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                if (3'(i) < retire_cnt) begin
                    vld_q[win_idx[i]]  <= 1'b0;
                    done_q[win_idx[i]] <= 1'b0;
                end
            end
            if (wr_en) begin
                for (int i = 0; i < `ALLOC_WIDTH; i++) begin
                    vld_q[alloc_idx[i]]  <= 1'b1;
                    // empty slots are complete on arrival
                    done_q[alloc_idx[i]] <= ~alloc_slots[i];
                end
            end
        end
    end

    // an empty slot never frees a register
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < `ALLOC_WIDTH; i++) begin
                reg_wrt_q[alloc_idx[i]]   <= alloc_reg_wrt[i] & alloc_slots[i];
                free_preg_q[alloc_idx[i]] <= alloc_free_preg[i];
            end
        end
    end

    // four oldest entries for the commit scan
    always_comb begin
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            head_window[i].valid     = vld_q[win_idx[i]];
            head_window[i].done      = done_q[win_idx[i]];
            head_window[i].reg_wrt   = reg_wrt_q[win_idx[i]];
            head_window[i].free_preg = free_preg_q[win_idx[i]];
        end
    end

endmodule

`default_nettype wire

/* design/rob_commit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_commit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rob_pkg::rob_entry_t  head_window [`COMMIT_WIDTH],
    output rob_pkg::rob_idx_t    head,
    output logic [2:0]           retire_cnt,
    output logic [2:0]           free_cnt,
    output rob_pkg::preg_group_t free_pregs
);

    // done run starting at head, one bit per window slot
    logic [`COMMIT_WIDTH-1:0] run;

    always_comb begin
        run[0] = head_window[0].valid & head_window[0].done;
        for (int i = 1; i < `COMMIT_WIDTH; i++) begin
            run[i] = run[i-1] & head_window[i].valid & head_window[i].done;
        end
    end

    // run is a prefix, so its popcount is the retire count
    always_comb begin
        retire_cnt = '0;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            retire_cnt = retire_cnt + 3'(run[i]);
        end
    end

    // pack freed registers oldest first
    always_comb begin
        free_cnt   = '0;
        free_pregs = '0;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            if (run[i] && head_window[i].reg_wrt) begin
                free_pregs[free_cnt[1:0]] = head_window[i].free_preg;
                free_cnt = free_cnt + 3'd1;
            end
        end
    end

    // unused slots stay zero from the default above

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
        end else begin
            // wraps with the index width
            head <= head + rob_pkg::rob_idx_t'(retire_cnt);
        end
    end

endmodule

`default_nettype wire

/* design/rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 alloc_vld,
    input  rob_pkg::slot_mask_t  alloc_slots,
    input  rob_pkg::slot_mask_t  alloc_reg_wrt,
    input  rob_pkg::preg_group_t alloc_free_preg,
    input  logic                 wb0_vld,
    input  logic                 wb1_vld,
    input  rob_pkg::rob_idx_t    wb0_idx,
    input  rob_pkg::rob_idx_t    wb1_idx,
    output rob_pkg::rob_idx_t    next_idx,
    output logic                 full,
    output logic                 empty,
    output logic [2:0]           free_cnt,
    output rob_pkg::preg_group_t free_pregs
);

    logic                wr_en;
    rob_pkg::rob_idx_t   head;
    logic [2:0]          retire_cnt;
    rob_pkg::rob_entry_t head_window [`COMMIT_WIDTH];

    // tail doubles as the index handed to the next group
    rob_alloc i_alloc (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_vld  (alloc_vld),
        .retire_cnt (retire_cnt),
        .wr_en      (wr_en),
        .tail       (next_idx),
        .full       (full),
        .empty      (empty)
    );

    rob_entry_table i_table (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr_en           (wr_en),
        .tail            (next_idx),
        .alloc_slots     (alloc_slots),
        .alloc_reg_wrt   (alloc_reg_wrt),
        .alloc_free_preg (alloc_free_preg),
        .wb0_vld         (wb0_vld),
        .wb1_vld         (wb1_vld),
        .wb0_idx         (wb0_idx),
        .wb1_idx         (wb1_idx),
        .head            (head),
        .retire_cnt      (retire_cnt),
        .head_window     (head_window)
    );

    rob_commit i_commit (
        .clk         (clk),
        .rst_n       (rst_n),
        .head_window (head_window),
        .head        (head),
        .retire_cnt  (retire_cnt),
        .free_cnt    (free_cnt),
        .free_pregs  (free_pregs)
    );

endmodule

`default_nettype wire

/* bench/rob_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_assertions (
    input logic              clk,
    input logic              rst_n,
    input logic              full,
    input logic              empty,
    input logic [2:0]        free_cnt,
    input rob_pkg::rob_idx_t next_idx
);

    // failing assertions seen so far
    int fail_cnt = 0;

    a_free_cnt_max: assert property (
        @(posedge clk) disable iff (!rst_n) free_cnt <= 3'd4
    ) else begin
        $error("free_cnt is above four");
        fail_cnt++;
    end

    a_full_not_empty: assert property (
        @(posedge clk) disable iff (!rst_n) !(full && empty)
    ) else begin
        $error("full and empty are high together");
        fail_cnt++;
    end

    // a group offered while full must not move the tail
    a_hold_idx_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) full |=> $stable(next_idx)
    ) else begin
        $error("next_idx moved after a cycle with full high");
        fail_cnt++;
    end

endmodule

`default_nettype wire

/* bench/rob_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 alloc_vld,
    input  rob_pkg::slot_mask_t  alloc_slots,
    input  rob_pkg::slot_mask_t  alloc_reg_wrt,
    input  rob_pkg::preg_group_t alloc_free_preg,
    input  logic                 wb0_vld,
    input  logic                 wb1_vld,
    input  rob_pkg::rob_idx_t    wb0_idx,
    input  rob_pkg::rob_idx_t    wb1_idx,
    input  rob_pkg::rob_idx_t    next_idx,
    input  logic                 full,
    input  logic                 empty,
    input  logic [2:0]           free_cnt,
    input  rob_pkg::preg_group_t free_pregs,
    output int                   chk_cnt,
    output int                   err_cnt
);

    // reference copy of the buffer, in age order from m_head
    logic [`ROB_DEPTH-1:0] m_done;
    logic [`ROB_DEPTH-1:0] m_wrt;
    rob_pkg::preg_t        m_preg [`ROB_DEPTH];
    rob_pkg::rob_idx_t     m_head;
    rob_pkg::rob_idx_t     m_tail;
    int                    m_cnt;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        rob_pkg::preg_group_t exp_pregs;
        rob_pkg::rob_idx_t    idx;
        int                   n_ret;
        int                   n_free;
        logic                 exp_full;
        if (!rst_n) begin
            m_done  = '0;
            m_head  = '0;
            m_tail  = '0;
            m_cnt   = 0;
            chk_cnt = 0;
            err_cnt = 0;
        end else begin
            // oldest done entries leave first, at most four
            n_ret     = 0;
            n_free    = 0;
            exp_pregs = '0;
            idx       = m_head;
            while (n_ret < `COMMIT_WIDTH && n_ret < m_cnt && m_done[idx]) begin
                if (m_wrt[idx]) begin
                    exp_pregs[n_free] = m_preg[idx];
                    n_free++;
                end
                m_done[idx] = 1'b0;
                idx = idx + rob_pkg::rob_idx_t'(1);
                n_ret++;
            end
            exp_full = (m_cnt > `ROB_DEPTH - `ALLOC_WIDTH);
            compare("free_cnt", 32'(free_cnt), 32'(n_free));
            compare("free_pregs", 32'(free_pregs), 32'(exp_pregs));
            compare("next_idx", 32'(next_idx), 32'(m_tail));
            compare("full", 32'(full), 32'(exp_full));
            compare("empty", 32'(empty), 32'(m_cnt == 0));
            // state after this edge
            m_head = idx;
            m_cnt  = m_cnt - n_ret;
            if (wb0_vld) begin
                m_done[wb0_idx] = 1'b1;
            end
            if (wb1_vld) begin
                m_done[wb1_idx] = 1'b1;
            end
            if (alloc_vld && !exp_full) begin
                for (int i = 0; i < `ALLOC_WIDTH; i++) begin
                    idx = m_tail + rob_pkg::rob_idx_t'(i);
                    m_done[idx] = ~alloc_slots[i];
                    m_wrt[idx]  = alloc_slots[i] & alloc_reg_wrt[i];
                    m_preg[idx] = alloc_free_preg[i];
                end
                m_tail = m_tail + rob_pkg::rob_idx_t'(`ALLOC_WIDTH);
                m_cnt  = m_cnt + `ALLOC_WIDTH;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/rob_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_tb;

    localparam int NUM_ROWS   = 12;
    localparam int WAIT_LIMIT = 200;

    // one allocation group and the completions issued after it
    typedef struct packed {
        rob_pkg::slot_mask_t  slots;
        rob_pkg::slot_mask_t  reg_wrt;
        rob_pkg::preg_group_t pregs;
        logic [7:0]           n_wb;
        logic                 drop;
    } row_t;

    logic                 clk;
    logic                 rst_n;
    logic                 alloc_vld;
    rob_pkg::slot_mask_t  alloc_slots;
    rob_pkg::slot_mask_t  alloc_reg_wrt;
    rob_pkg::preg_group_t alloc_free_preg;
    logic                 wb0_vld;
    logic                 wb1_vld;
    rob_pkg::rob_idx_t    wb0_idx;
    rob_pkg::rob_idx_t    wb1_idx;
    rob_pkg::rob_idx_t    next_idx;
    logic                 full;
    logic                 empty;
    logic [2:0]           free_cnt;
    rob_pkg::preg_group_t free_pregs;
    int                   chk_cnt;
    int                   err_cnt;

    // indices allocated but not yet written back
    rob_pkg::rob_idx_t pend [$];
    rob_pkg::rob_idx_t tail;
    logic              timed_out;

    // rows 0-3 fill the buffer, row 4 arrives while full
    row_t rows [NUM_ROWS] = '{
        '{4'b1111, 4'b1111, {6'd4, 6'd3, 6'd2, 6'd1}, 8'd0, 1'b0},
        '{4'b1111, 4'b1111, {6'd8, 6'd7, 6'd6, 6'd5}, 8'd0, 1'b0},
        '{4'b1111, 4'b1111, {6'd12, 6'd11, 6'd10, 6'd9}, 8'd0, 1'b0},
        '{4'b1111, 4'b1111, {6'd16, 6'd15, 6'd14, 6'd13}, 8'd0, 1'b0},
        '{4'b1111, 4'b1111, {6'd20, 6'd19, 6'd18, 6'd17}, 8'd16, 1'b1},
        '{4'b1010, 4'b1111, {6'd24, 6'd23, 6'd22, 6'd21}, 8'd3, 1'b0},
        '{4'b1111, 4'b0110, {6'd28, 6'd27, 6'd26, 6'd25}, 8'd2, 1'b0},
        // empty group, all slots retire without freeing
        '{4'b0000, 4'b1111, {6'd32, 6'd31, 6'd30, 6'd29}, 8'd0, 1'b0},
        '{4'b1111, 4'b1011, {6'd36, 6'd35, 6'd34, 6'd33}, 8'd4, 1'b0},
        '{4'b1101, 4'b1101, {6'd40, 6'd39, 6'd38, 6'd37}, 8'd2, 1'b0},
        '{4'b1111, 4'b1111, {6'd44, 6'd43, 6'd42, 6'd41}, 8'd6, 1'b0},
        '{4'b0111, 4'b0101, {6'd48, 6'd47, 6'd46, 6'd45}, 8'd8, 1'b0}
    };

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    rob_top i_dut (.*);

    rob_checker i_checker (.*);

    bind rob_top rob_assertions i_assertions (.*);

    // random outstanding entry, removed from the list
    task automatic pick_pending(output logic vld, output rob_pkg::rob_idx_t idx);
        int k;
        vld = 1'b0;
        idx = '0;
        if (pend.size() > 0) begin
            k = int'($urandom % pend.size());
            idx = pend[k];
            pend.delete(k);
            vld = 1'b1;
        end
    endtask

    // up to two completions per cycle
    task automatic issue_writebacks(input int n);
        int left;
        left = n;
        while (left > 0 && pend.size() > 0) begin
            pick_pending(wb0_vld, wb0_idx);
            left--;
            if (left > 0) begin
                pick_pending(wb1_vld, wb1_idx);
                left--;
            end
            @(negedge clk);
            wb0_vld = 1'b0;
            wb1_vld = 1'b0;
        end
    endtask

    task automatic offer_group(input row_t row);
        alloc_vld       = 1'b1;
        alloc_slots     = row.slots;
        alloc_reg_wrt   = row.reg_wrt;
        alloc_free_preg = row.pregs;
        if (!row.drop) begin
            for (int i = 0; i < `ALLOC_WIDTH; i++) begin
                if (row.slots[i]) begin
                    pend.push_back(tail + rob_pkg::rob_idx_t'(i));
                end
            end
            tail = tail + rob_pkg::rob_idx_t'(`ALLOC_WIDTH);
        end
        @(negedge clk);
        alloc_vld = 1'b0;
    endtask

    // wait for room, or for an empty buffer, completing entries meanwhile
    task automatic wait_drain(input logic until_empty);
        int t;
        t = 0;
        while ((until_empty ? !empty : full) && t < WAIT_LIMIT) begin
            if (pend.size() > 0) begin
                issue_writebacks(2);
            end else begin
                @(negedge clk);
            end
            t++;
        end
        if (until_empty ? !empty : full) begin
            $display("timeout: the buffer did not %s", until_empty ? "empty" : "leave full");
            timed_out = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(32'h6d10));
        rst_n           = 1'b0;
        alloc_vld       = 1'b0;
        alloc_slots     = '0;
        alloc_reg_wrt   = '0;
        alloc_free_preg = '0;
        wb0_vld         = 1'b0;
        wb1_vld         = 1'b0;
        wb0_idx         = '0;
        wb1_idx         = '0;
        tail            = '0;
        timed_out       = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            // a dropped row goes out while full is still high
            if (!timed_out && !rows[r].drop) begin
                wait_drain(1'b0);
            end
            if (!timed_out) begin
                offer_group(rows[r]);
                issue_writebacks(int'(rows[r].n_wb));
            end
        end
        if (!timed_out) begin
            wait_drain(1'b1);
        end
        @(negedge clk);
        $display("checks %0d, value errors %0d, assertion failures %0d, timeouts %0d",
                 chk_cnt, err_cnt, i_dut.i_assertions.fail_cnt, int'(timed_out));
        if (timed_out || err_cnt != 0 || i_dut.i_assertions.fail_cnt != 0 || chk_cnt == 0) begin
            $display("Testbench failed");
        end else begin
            $display("Testbench passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+design
design/rob_pkg.sv
design/rob_alloc.sv
design/rob_entry_table.sv
design/rob_commit.sv
design/rob_top.sv
bench/rob_assertions.sv
bench/rob_checker.sv
bench/rob_tb.sv

/* Makefile */
TOP       ?= rob_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(wildcard design/*.sv design/*.svh bench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@grep -qx "Testbench passed" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
